// ==== logic/eth_tx_pkg.sv ====
package eth_tx_pkg;

    // framing bytes ahead of the destination address
    localparam logic [7:0] eth_pre = 8'h55;
    localparam logic [7:0] eth_sfd = 8'hD5;

    // crc-32 polynomial in normal bit order
    localparam logic [31:0] crc_poly = 32'h04C11DB7;
    localparam logic [31:0] crc_init = 32'hFFFFFFFF;

    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_preamble = 3'd1,
        st_payload  = 3'd2,
        st_last     = 3'd3,
        st_pad      = 3'd4,
        st_fcs      = 3'd5,
        st_wait_end = 3'd6,
        st_ifg      = 3'd7
    } tx_state_t;

    // register map, two writable then two read-only counters
    typedef enum logic [1:0] {
        addr_ifg_delay   = 2'd0,
        addr_mode        = 2'd1,
        addr_frame_count = 2'd2,
        addr_error_count = 2'd3
    } cfg_addr_t;

endpackage

// ==== logic/eth_crc32.sv ====
module eth_crc32 (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic        crc_init_en,
    input  logic        crc_update,
    input  logic [7:0]  crc_data,
    output logic [31:0] crc_value
);

    function automatic logic [31:0] reflect32(input logic [31:0] value);
        logic [31:0] result;
        for (int i = 0; i < 32; i++) begin
            result[i] = value[31 - i];
        end
        return result;
    endfunction

    // ethernet shifts lsb first, so the polynomial is mirrored
    localparam logic [31:0] poly_rev = reflect32(eth_tx_pkg::crc_poly);

    logic [31:0] crc_reg;
    logic [31:0] crc_step;

    // one byte, eight single-bit shifts
    always_comb begin
        crc_step = crc_reg ^ {24'd0, crc_data};
        for (int i = 0; i < 8; i++) begin
            if (crc_step[0]) begin
                crc_step = (crc_step >> 1) ^ poly_rev;
            end else begin
                crc_step = crc_step >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_init_en) begin
            crc_reg <= eth_tx_pkg::crc_init;
        end else if (crc_update) begin
            crc_reg <= crc_step;
        end
    end

    assign crc_value = crc_reg;

endmodule

// ==== logic/gmii_tx_framer.sv ====
module gmii_tx_framer #(
    parameter bit enable_padding   = 1'b1,
    parameter int min_frame_length = 64
) (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic        clk_enable,
    input  logic        mii_select,
    input  logic [7:0]  ifg_delay,
    input  logic [7:0]  s_tdata,
    input  logic        s_tvalid,
    output logic        s_tready,
    input  logic        s_tlast,
    input  logic        s_tuser,
    output logic [7:0]  gmii_txd,
    output logic        gmii_tx_en,
    output logic        gmii_tx_er,
    output logic        start_packet,
    output logic        frame_abort,
    output logic        crc_init_en,
    output logic        crc_update,
    output logic [7:0]  crc_data,
    input  logic [31:0] crc_value
);

    // last payload index that still needs a pad byte after it
    localparam logic [15:0] pad_limit =
        16'((min_frame_length > 5) ? min_frame_length - 5 : 0);

    eth_tx_pkg::tx_state_t state_reg, state_next;

    logic [15:0] frame_ptr_reg, frame_ptr_next;
    logic [7:0]  in_data_reg, in_data_next;
    logic        in_last_reg, in_last_next;
    logic        in_user_reg, in_user_next;
    logic        mii_odd_reg, mii_odd_next;
    logic [3:0]  mii_msn_reg, mii_msn_next;
    logic        s_tready_reg, s_tready_next;
    logic [7:0]  txd_reg, txd_next;
    logic        tx_en_reg, tx_en_next;
    logic        tx_er_reg, tx_er_next;
    logic        start_packet_reg, start_packet_next;
    logic        frame_abort_reg, frame_abort_next;
    logic        pad_needed;
    logic        ifg_done;

    assign pad_needed = enable_padding && (frame_ptr_reg < pad_limit);
    assign ifg_done   = (frame_ptr_reg + 16'd1) >= {8'd0, ifg_delay};

    // crc always folds the byte held in the input register
    assign crc_data = in_data_reg;

    always_comb begin
        state_next        = state_reg;
        frame_ptr_next    = frame_ptr_reg;
        in_data_next      = in_data_reg;
        in_last_next      = in_last_reg;
        in_user_next      = in_user_reg;
        mii_odd_next      = mii_odd_reg;
        mii_msn_next      = mii_msn_reg;
        s_tready_next     = s_tready_reg;
        txd_next          = txd_reg;
        tx_en_next        = tx_en_reg;
        tx_er_next        = tx_er_reg;
        start_packet_next = 1'b0;
        frame_abort_next  = 1'b0;
        crc_init_en       = 1'b0;
        crc_update        = 1'b0;

        if (clk_enable) begin
            if (mii_select && mii_odd_reg) begin
                // second half of the byte time, high nibble
                mii_odd_next  = 1'b0;
                s_tready_next = 1'b0;
                txd_next      = {4'd0, mii_msn_reg};
            end else begin
                s_tready_next = 1'b0;
                txd_next      = 8'd0;
                tx_en_next    = 1'b0;
                tx_er_next    = 1'b0;

                case (state_reg)
                    eth_tx_pkg::st_idle: begin
                        crc_init_en  = 1'b1;
                        mii_odd_next = 1'b0;
                        if (s_tvalid) begin
                            mii_odd_next   = 1'b1;
                            frame_ptr_next = 16'd1;
                            txd_next       = eth_tx_pkg::eth_pre;
                            tx_en_next     = 1'b1;
                            state_next     = eth_tx_pkg::st_preamble;
                        end
                    end
                    eth_tx_pkg::st_preamble: begin
                        crc_init_en    = 1'b1;
                        mii_odd_next   = 1'b1;
                        tx_en_next     = 1'b1;
                        txd_next       = eth_tx_pkg::eth_pre;
                        frame_ptr_next = frame_ptr_reg + 16'd1;
                        if (frame_ptr_reg == 16'd6) begin
                            // first byte is held on the bus until taken
                            in_data_next  = s_tdata;
                            in_last_next  = s_tlast;
                            in_user_next  = s_tuser;
                            s_tready_next = 1'b1;
                        end else if (frame_ptr_reg == 16'd7) begin
                            txd_next          = eth_tx_pkg::eth_sfd;
                            start_packet_next = 1'b1;
                            frame_ptr_next    = 16'd0;
                            // gmii takes byte 0 now, mii took it on the odd cycle
                            s_tready_next     = !mii_select && !in_last_reg;
                            state_next        = in_last_reg ? eth_tx_pkg::st_last
                                                            : eth_tx_pkg::st_payload;
                        end
                    end
                    eth_tx_pkg::st_payload: begin
                        crc_update     = 1'b1;
                        mii_odd_next   = 1'b1;
                        tx_en_next     = 1'b1;
                        txd_next       = in_data_reg;
                        frame_ptr_next = frame_ptr_reg + 16'd1;
                        if (s_tvalid) begin
                            in_data_next  = s_tdata;
                            in_last_next  = s_tlast;
                            in_user_next  = s_tuser;
                            s_tready_next = mii_select || !s_tlast;
                            if (s_tlast) begin
                                state_next = eth_tx_pkg::st_last;
                            end
                        end else begin
                            // source ran dry mid-frame
                            tx_er_next       = 1'b1;
                            frame_abort_next = 1'b1;
                            frame_ptr_next   = 16'd0;
                            state_next       = eth_tx_pkg::st_wait_end;
                        end
                    end
                    eth_tx_pkg::st_last: begin
                        mii_odd_next   = 1'b1;
                        tx_en_next     = 1'b1;
                        txd_next       = in_data_reg;
                        frame_ptr_next = frame_ptr_reg + 16'd1;
                        if (in_user_reg) begin
                            // bad frame, no fcs
                            tx_er_next       = 1'b1;
                            frame_abort_next = 1'b1;
                            frame_ptr_next   = 16'd0;
                            state_next       = eth_tx_pkg::st_ifg;
                        end else begin
                            crc_update = 1'b1;
                            if (pad_needed) begin
                                in_data_next = 8'd0;
                                state_next   = eth_tx_pkg::st_pad;
                            end else begin
                                frame_ptr_next = 16'd0;
                                state_next     = eth_tx_pkg::st_fcs;
                            end
                        end
                    end
                    eth_tx_pkg::st_pad: begin
                        crc_update     = 1'b1;
                        mii_odd_next   = 1'b1;
                        tx_en_next     = 1'b1;
                        txd_next       = 8'd0;
                        frame_ptr_next = frame_ptr_reg + 16'd1;
                        if (!pad_needed) begin
                            frame_ptr_next = 16'd0;
                            state_next     = eth_tx_pkg::st_fcs;
                        end
                    end
                    eth_tx_pkg::st_fcs: begin
                        mii_odd_next   = 1'b1;
                        tx_en_next     = 1'b1;
                        // inverted remainder, low byte first
                        txd_next       = ~crc_value[8 * frame_ptr_reg[1:0] +: 8];
                        frame_ptr_next = frame_ptr_reg + 16'd1;
                        if (frame_ptr_reg[1:0] == 2'd3) begin
                            frame_ptr_next = 16'd0;
                            state_next     = eth_tx_pkg::st_ifg;
                        end
                    end
                    eth_tx_pkg::st_wait_end: begin
                        // drain the rest of an aborted frame
                        crc_init_en    = 1'b1;
                        mii_odd_next   = 1'b0;
                        frame_ptr_next = frame_ptr_reg + 16'd1;
                        s_tready_next  = 1'b1;
                        if (s_tready_reg && s_tvalid && s_tlast) begin
                            s_tready_next = 1'b0;
                            state_next    = ifg_done ? eth_tx_pkg::st_idle
                                                     : eth_tx_pkg::st_ifg;
                        end
                    end
                    eth_tx_pkg::st_ifg: begin
                        crc_init_en    = 1'b1;
                        mii_odd_next   = 1'b1;
                        frame_ptr_next = frame_ptr_reg + 16'd1;
                        if (ifg_done) begin
                            state_next = eth_tx_pkg::st_idle;
                        end
                    end
                    default: begin
                        state_next = eth_tx_pkg::st_idle;
                    end
                endcase

                // mii sends the low nibble now and keeps the high one
                if (mii_select) begin
                    mii_msn_next  = txd_next[7:4];
                    txd_next[7:4] = 4'd0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state_reg        <= eth_tx_pkg::st_idle;
            frame_ptr_reg    <= 16'd0;
            mii_odd_reg      <= 1'b0;
            s_tready_reg     <= 1'b0;
            tx_en_reg        <= 1'b0;
            tx_er_reg        <= 1'b0;
            start_packet_reg <= 1'b0;
            frame_abort_reg  <= 1'b0;
        end else begin
            state_reg        <= state_next;
            frame_ptr_reg    <= frame_ptr_next;
            mii_odd_reg      <= mii_odd_next;
            s_tready_reg     <= s_tready_next;
            tx_en_reg        <= tx_en_next;
            tx_er_reg        <= tx_er_next;
            start_packet_reg <= start_packet_next;
            frame_abort_reg  <= frame_abort_next;
        end

        in_data_reg <= in_data_next;
        in_last_reg <= in_last_next;
        in_user_reg <= in_user_next;
        mii_msn_reg <= mii_msn_next;
        txd_reg     <= txd_next;
    end

    assign s_tready     = s_tready_reg;
    assign gmii_txd     = txd_reg;
    assign gmii_tx_en   = tx_en_reg;
    assign gmii_tx_er   = tx_er_reg;
    assign start_packet = start_packet_reg;
    assign frame_abort  = frame_abort_reg;

endmodule

// ==== logic/tx_config_regs.sv ====
module tx_config_regs #(
    parameter int count_width = 16
) (
    input  logic                   clk,
    input  logic                   reset_crc,
    input  logic                   cfg_wr,
    input  logic [1:0]             cfg_addr,
    input  logic [7:0]             cfg_wdata,
    output logic [count_width-1:0] cfg_rdata,
    input  logic                   start_packet,
    input  logic                   frame_abort,
    output logic [7:0]             ifg_delay,
    output logic                   mii_select
);

    eth_tx_pkg::cfg_addr_t  addr;
    logic [count_width-1:0] frame_count;
    logic [count_width-1:0] error_count;

    // counters stop at all ones
    function automatic logic [count_width-1:0] sat_inc(
        input logic [count_width-1:0] count,
        input logic                   pulse
    );
        if (pulse && (count != '1)) begin
            return count + 1'b1;
        end
        return count;
    endfunction

    assign addr = eth_tx_pkg::cfg_addr_t'(cfg_addr);

    // writable registers
    always_ff @(posedge clk) begin
        if (reset_crc) begin
            ifg_delay  <= 8'd12;
            mii_select <= 1'b0;
        end else if (cfg_wr) begin
            if (addr == eth_tx_pkg::addr_ifg_delay) begin
                ifg_delay <= cfg_wdata;
            end
            if (addr == eth_tx_pkg::addr_mode) begin
                mii_select <= cfg_wdata[0];
            end
        end
    end

    // status counters
    always_ff @(posedge clk) begin
        if (reset_crc) begin
            frame_count <= '0;
            error_count <= '0;
        end else begin
            frame_count <= sat_inc(frame_count, start_packet);
            error_count <= sat_inc(error_count, frame_abort);
        end
    end

    // read data lags the address by one cycle
    always_ff @(posedge clk) begin
        case (addr)
            eth_tx_pkg::addr_ifg_delay: begin
                cfg_rdata <= count_width'(ifg_delay);
            end
            eth_tx_pkg::addr_mode: begin
                cfg_rdata <= count_width'(mii_select);
            end
            eth_tx_pkg::addr_frame_count: begin
                cfg_rdata <= frame_count;
            end
            default: begin
                cfg_rdata <= error_count;
            end
        endcase
    end

endmodule

// ==== logic/eth_tx_top.sv ====
module eth_tx_top #(
    parameter bit enable_padding   = 1'b1,
    parameter int min_frame_length = 64,
    parameter int count_width      = 16
) (
    input  logic                   clk,
    input  logic                   reset_crc,
    input  logic                   clk_enable,
    input  logic [7:0]             s_tdata,
    input  logic                   s_tvalid,
    output logic                   s_tready,
    input  logic                   s_tlast,
    input  logic                   s_tuser,
    output logic [7:0]             gmii_txd,
    output logic                   gmii_tx_en,
    output logic                   gmii_tx_er,
    input  logic                   cfg_wr,
    input  logic [1:0]             cfg_addr,
    input  logic [7:0]             cfg_wdata,
    output logic [count_width-1:0] cfg_rdata
);

    // framer to crc
    logic        crc_init_en;
    logic        crc_update;
    logic [7:0]  crc_data;
    logic [31:0] crc_value;

    // framer and register block
    logic        start_packet;
    logic        frame_abort;
    logic [7:0]  ifg_delay;
    logic        mii_select;

    gmii_tx_framer #(
        .enable_padding   (enable_padding),
        .min_frame_length (min_frame_length)
    ) u_framer (
        .clk          (clk),
        .reset_crc    (reset_crc),
        .clk_enable   (clk_enable),
        .mii_select   (mii_select),
        .ifg_delay    (ifg_delay),
        .s_tdata      (s_tdata),
        .s_tvalid     (s_tvalid),
        .s_tready     (s_tready),
        .s_tlast      (s_tlast),
        .s_tuser      (s_tuser),
        .gmii_txd     (gmii_txd),
        .gmii_tx_en   (gmii_tx_en),
        .gmii_tx_er   (gmii_tx_er),
        .start_packet (start_packet),
        .frame_abort  (frame_abort),
        .crc_init_en  (crc_init_en),
        .crc_update   (crc_update),
        .crc_data     (crc_data),
        .crc_value    (crc_value)
    );

    eth_crc32 u_crc (
        .clk         (clk),
        .reset_crc   (reset_crc),
        .crc_init_en (crc_init_en),
        .crc_update  (crc_update),
        .crc_data    (crc_data),
        .crc_value   (crc_value)
    );

    tx_config_regs #(
        .count_width (count_width)
    ) u_regs (
        .clk          (clk),
        .reset_crc    (reset_crc),
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .start_packet (start_packet),
        .frame_abort  (frame_abort),
        .ifg_delay    (ifg_delay),
        .mii_select   (mii_select)
    );

endmodule

// ==== sim/eth_tx_checker.sv ====
module eth_tx_checker (
    input logic                  clk,
    input logic                  reset_crc,
    input logic                  tx_en,
    input logic                  tx_er,
    input logic                  s_tready,
    input eth_tx_pkg::tx_state_t state
);

    // allowed successors of each state
    function automatic bit legal_step(
        input eth_tx_pkg::tx_state_t prev,
        input eth_tx_pkg::tx_state_t curr
    );
        case (prev)
            eth_tx_pkg::st_idle:     return curr == eth_tx_pkg::st_preamble;
            eth_tx_pkg::st_preamble: return curr inside {eth_tx_pkg::st_payload,
                                                         eth_tx_pkg::st_last};
            eth_tx_pkg::st_payload:  return curr inside {eth_tx_pkg::st_last,
                                                         eth_tx_pkg::st_wait_end};
            eth_tx_pkg::st_last:     return curr inside {eth_tx_pkg::st_pad,
                                                         eth_tx_pkg::st_fcs,
                                                         eth_tx_pkg::st_ifg};
            eth_tx_pkg::st_pad:      return curr == eth_tx_pkg::st_fcs;
            eth_tx_pkg::st_fcs:      return curr == eth_tx_pkg::st_ifg;
            eth_tx_pkg::st_wait_end: return curr inside {eth_tx_pkg::st_idle,
                                                         eth_tx_pkg::st_ifg};
            eth_tx_pkg::st_ifg:      return curr == eth_tx_pkg::st_idle;
            default:                 return 1'b0;
        endcase
    endfunction

    // error strobe only inside a frame
    assert property (@(posedge clk) disable iff (reset_crc) tx_er |-> tx_en)
        else $error("gmii_tx_er high while gmii_tx_en is low");

    // no stream data taken while idle or in the gap
    assert property (@(posedge clk) disable iff (reset_crc)
        (state == eth_tx_pkg::st_idle || state == eth_tx_pkg::st_ifg) |-> !s_tready)
        else $error("s_tready high in idle or ifg state");

    // state moves only along the frame sequence
    assert property (@(posedge clk) disable iff (reset_crc)
        (state != $past(state)) |-> legal_step($past(state), state))
        else $error("framer state took an illegal transition");

endmodule

// ==== sim/eth_tx_tb.sv ====
module eth_tx_tb;

    localparam int          min_len     = 64;
    localparam int          count_width = 16;
    localparam int unsigned seed        = 96;
    localparam int          frame_count = 8;
    localparam int          timeout     = 4000;

    logic                   clk;
    logic                   reset_crc;
    logic                   clk_enable;
    logic [7:0]             s_tdata;
    logic                   s_tvalid;
    logic                   s_tready;
    logic                   s_tlast;
    logic                   s_tuser;
    logic [7:0]             gmii_txd;
    logic                   gmii_tx_en;
    logic                   gmii_tx_er;
    logic                   cfg_wr;
    logic [1:0]             cfg_addr;
    logic [7:0]             cfg_wdata;
    logic [count_width-1:0] cfg_rdata;

    int unsigned rng_state = seed;
    int unsigned en_state  = seed + 7;
    bit          en_random;
    bit          mii_mode;
    int          ifg_expect;
    int          started;
    int          aborted;

    // expected frames and a flat byte stream of the good ones
    logic [7:0]  payload[$];
    logic [7:0]  exp_bytes[$];
    int          exp_len[$];
    bit          exp_abort[$];

    // monitor state
    logic [7:0]  got[$];
    logic [3:0]  low_nib;
    bit          half;
    bit          in_frame;
    bit          er_seen;
    int          gap_cycles;
    int          frames_seen;

    eth_tx_top #(
        .enable_padding   (1'b1),
        .min_frame_length (min_len),
        .count_width      (count_width)
    ) UUT (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .clk_enable (clk_enable),
        .s_tdata    (s_tdata),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .s_tlast    (s_tlast),
        .s_tuser    (s_tuser),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata)
    );

    bind gmii_tx_framer eth_tx_checker u_checker (
        .clk       (clk),
        .reset_crc (reset_crc),
        .tx_en     (gmii_tx_en),
        .tx_er     (gmii_tx_er),
        .s_tready  (s_tready),
        .state     (state_reg)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned lcg_step(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int rand_below(input int n);
        rng_state = lcg_step(rng_state);
        return int'((rng_state >> 16) % n);
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // about one cycle in four has the enable low
    initial begin
        clk_enable = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            en_state = lcg_step(en_state);
            clk_enable = en_random ? (en_state[17:16] != 2'd0) : 1'b1;
        end
    end

    task automatic check_frame();
        int          n;
        bit          ab;
        logic [7:0]  e;
        assert (exp_len.size() > 0)
            else report_error("a frame appeared on the GMII bus with none expected");
        n  = exp_len.pop_front();
        ab = exp_abort.pop_front();
        if (ab) begin
            assert (er_seen) else report_error($sformatf(
                "FAILED time %0t signal gmii_tx_er: got 0, expected 1", $time));
            assert (got.size() < n) else report_error($sformatf(
                "FAILED time %0t signal gmii_tx_en length: got %0d, expected below %0d",
                $time, got.size(), n));
        end else begin
            assert (!er_seen) else report_error($sformatf(
                "FAILED time %0t signal gmii_tx_er: got 1, expected 0", $time));
            assert (got.size() == n) else report_error($sformatf(
                "FAILED time %0t signal gmii_tx_en length: got %0d, expected %0d",
                $time, got.size(), n));
            for (int i = 0; i < n; i++) begin
                e = exp_bytes.pop_front();
                assert (got[i] === e) else report_error($sformatf(
                    "FAILED time %0t signal gmii_txd byte %0d: got %02h, expected %02h",
                    $time, i, got[i], e));
            end
        end
    endtask

    // outputs sampled at negedge on enabled cycles
    always @(negedge clk) begin
        if (!reset_crc && clk_enable) begin
            if (gmii_tx_en) begin
                if (!in_frame && frames_seen > 0) begin
                    assert (gap_cycles >= ifg_expect) else report_error($sformatf(
                        "FAILED time %0t signal gmii_tx_en gap: got %0d, expected %0d",
                        $time, gap_cycles, ifg_expect));
                end
                in_frame = 1'b1;
                if (gmii_tx_er) begin
                    er_seen = 1'b1;
                end
                if (mii_mode) begin
                    assert (gmii_txd[7:4] == 4'd0) else report_error($sformatf(
                        "FAILED time %0t signal gmii_txd[7:4]: got %h, expected 0",
                        $time, gmii_txd[7:4]));
                    if (!half) begin
                        low_nib = gmii_txd[3:0];
                        half    = 1'b1;
                    end else begin
                        got.push_back({gmii_txd[3:0], low_nib});
                        half = 1'b0;
                    end
                end else begin
                    got.push_back(gmii_txd);
                end
            end else begin
                if (in_frame) begin
                    check_frame();
                    got.delete();
                    in_frame   = 1'b0;
                    er_seen    = 1'b0;
                    half       = 1'b0;
                    gap_cycles = 0;
                    frames_seen++;
                end
                gap_cycles++;
            end
        end
    end

    // builds the payload and the expected line bytes
    // kind 0 is good, 1 ends with tuser, 2 drops valid
    task automatic make_frame(input int len, input int kind);
        int          full;
        logic [31:0] crc;
        logic [7:0]  b;
        payload.delete();
        for (int i = 0; i < len; i++) begin
            payload.push_back(8'(rand_below(256)));
        end
        full = (len < min_len - 4) ? min_len - 4 : len;
        exp_len.push_back(12 + full);
        exp_abort.push_back(kind != 0);
        started++;
        if (kind != 0) begin
            aborted++;
        end else begin
            repeat (7) exp_bytes.push_back(8'h55);
            exp_bytes.push_back(8'hD5);
            crc = 32'hFFFFFFFF;
            for (int i = 0; i < full; i++) begin
                b = (i < len) ? payload[i] : 8'h00;
                exp_bytes.push_back(b);
                crc = crc ^ {24'd0, b};
                for (int j = 0; j < 8; j++) begin
                    crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
                end
            end
            crc = ~crc;
            for (int j = 0; j < 4; j++) begin
                exp_bytes.push_back(crc[8*j +: 8]);
            end
        end
    endtask

    task automatic send_frame(input bit bad_user, input bit drop_valid);
        int idx;
        int len;
        int t;
        len = payload.size();
        idx = 0;
        s_tvalid = 1'b1;
        while (idx < len) begin
            s_tdata = payload[idx];
            s_tlast = (idx == len - 1);
            s_tuser = bad_user && (idx == len - 1);
            t = 0;
            do begin
                @(negedge clk);
                t++;
                assert (t < timeout) else report_error("stream byte was never accepted");
            end while (!(s_tready && clk_enable));
            @(posedge clk);
            #1;
            idx++;
            if (drop_valid && idx == 2) begin
                s_tvalid = 1'b0;
                t = 0;
                do begin
                    @(negedge clk);
                    t++;
                    assert (t < timeout) else report_error("no tx_er after valid dropped");
                end while (!gmii_tx_er);
                @(posedge clk);
                #1;
                s_tvalid = 1'b1;
            end
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        s_tuser  = 1'b0;
    endtask

    task automatic run_frame(input int kind);
        int len;
        len = (kind == 2) ? 4 + rand_below(77) : 1 + rand_below(80);
        make_frame(len, kind);
        repeat (rand_below(4)) begin
            @(posedge clk);
            #1;
        end
        send_frame(kind == 1, kind == 2);
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (exp_len.size() > 0) begin
            @(posedge clk);
            t++;
            assert (t < timeout) else report_error("timeout waiting for frames to leave");
        end
        repeat (200) @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_wr = 1'b0;
    endtask

    task automatic check_reg(input logic [1:0] addr, input int expect_val, input string name);
        @(posedge clk);
        #1;
        cfg_addr = addr;
        @(posedge clk);
        @(negedge clk);
        assert (cfg_rdata == count_width'(expect_val)) else report_error($sformatf(
            "FAILED time %0t signal cfg_rdata %s: got %0d, expected %0d",
            $time, name, cfg_rdata, expect_val));
    endtask

    initial begin
        reset_crc  = 1'b1;
        s_tdata    = 8'd0;
        s_tvalid   = 1'b0;
        s_tlast    = 1'b0;
        s_tuser    = 1'b0;
        cfg_wr     = 1'b0;
        cfg_addr   = 2'd0;
        cfg_wdata  = 8'd0;
        ifg_expect = 12;
        repeat (5) @(posedge clk);
        #1;
        reset_crc = 1'b0;
        assert (gmii_tx_en === 1'b0) else report_error($sformatf(
            "FAILED time %0t signal gmii_tx_en: got %b, expected 0", $time, gmii_tx_en));
        assert (gmii_tx_er === 1'b0) else report_error($sformatf(
            "FAILED time %0t signal gmii_tx_er: got %b, expected 0", $time, gmii_tx_er));
        assert (s_tready === 1'b0) else report_error($sformatf(
            "FAILED time %0t signal s_tready: got %b, expected 0", $time, s_tready));
        check_reg(eth_tx_pkg::addr_ifg_delay, 12, "ifg_delay");
        check_reg(eth_tx_pkg::addr_mode, 0, "mode");
        check_reg(eth_tx_pkg::addr_frame_count, 0, "frame_count");
        check_reg(eth_tx_pkg::addr_error_count, 0, "error_count");

        // good gmii frames
        repeat (frame_count) run_frame(0);
        wait_drained();

        // several gap values
        repeat (3) begin
            ifg_expect = 1 + rand_below(24);
            write_reg(eth_tx_pkg::addr_ifg_delay, 8'(ifg_expect));
            repeat (3) run_frame(0);
            wait_drained();
        end

        // aborted frames with a good one after each
        run_frame(1);
        run_frame(0);
        run_frame(2);
        run_frame(0);
        wait_drained();

        // gated clock enable
        en_random = 1'b1;
        repeat (frame_count) run_frame(rand_below(5) == 0 ? 1 + rand_below(2) : 0);
        wait_drained();

        // mii mode
        write_reg(eth_tx_pkg::addr_mode, 8'd1);
        mii_mode = 1'b1;
        repeat (200) @(posedge clk);
        #1;
        repeat (frame_count) run_frame(rand_below(5) == 0 ? 1 + rand_below(2) : 0);
        run_frame(2);
        run_frame(0);
        wait_drained();
        en_random = 1'b0;

        check_reg(eth_tx_pkg::addr_mode, 1, "mode");
        check_reg(eth_tx_pkg::addr_frame_count, started, "frame_count");
        check_reg(eth_tx_pkg::addr_error_count, aborted, "error_count");

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== tb.f ====
logic/eth_tx_pkg.sv
logic/eth_crc32.sv
logic/gmii_tx_framer.sv
logic/tx_config_regs.sv
logic/eth_tx_top.sv
sim/eth_tx_checker.sv
sim/eth_tx_tb.sv
